//--- pc_guard_golden.txt
# ctrl = pc_set mux[2:0] kill_id kill_ex jump_raw branch_raw, flow = ifv idr idv exr exv wbr
# targets = jump branch mepc mtvec dpc boot nmi wb_next, then compressed bd id_ex_valid mask
# expected = pc_if pc_err alarm alert err_cnt (hex), last column = cycles held
# sequential fetch and back-pressure
10000000 000000 400 801 1202 3 1a05 1003 2c01 3000 0 0 0 0   1000 0 0 0 0  1
00000000 110000 400 801 1202 3 1a05 1003 2c01 3000 0 0 0 0   1000 0 0 0 0  1
00000000 110000 400 801 1202 3 1a05 1003 2c01 3000 1 0 0 0   1004 0 0 0 0  1
00000000 110000 400 801 1202 3 1a05 1003 2c01 3000 1 0 0 0   1006 0 0 0 0  1
00000000 110000 400 801 1202 3 1a05 1003 2c01 3000 0 0 0 0   1008 0 0 0 0  1
00000000 100000 400 801 1202 3 1a05 1003 2c01 3000 0 0 0 0   100c 0 0 0 0  1
00000000 100000 400 801 1202 3 1a05 1003 2c01 3000 1 0 0 0   100c 0 0 0 0  1
00000000 110000 400 801 1202 3 1a05 1003 2c01 3000 0 0 0 0   100c 0 0 0 0  1
# control-flow targets
10010000 000000 400 801 1202 3 1a05 1003 2c01 3000 0 0 0 0   1010 0 0 0 0  1
00000010 001100 400 801 1202 3 1a05 1003 2c01 3000 0 0 0 0   400  0 0 0 0  1
10100000 000000 400 801 1202 3 1a05 1003 2c01 3000 0 0 0 0   400  0 0 0 0  1
00000001 000011 400 801 1202 3 1a05 1003 2c01 3000 0 1 1 0   800  0 0 0 0  1
10110000 000000 400 801 1202 3 1a05 1003 2c01 3000 0 0 0 0   800  0 0 0 0  1
00000010 001100 400 801 1202 3 1a05 1003 2c01 3000 0 0 0 0   1202 0 0 0 0  1
11000000 000000 400 801 1202 3 1a05 1003 2c01 3000 0 0 0 0   1202 0 0 0 0  1
11010000 000000 400 801 1202 3 1a05 1003 2c01 3000 0 0 0 0   180  0 0 0 0  1
11100000 000000 400 801 1202 3 1a05 1003 2c01 3000 0 0 0 0   2c00 0 0 0 0  1
11110000 000000 400 801 1202 3 1a05 1003 2c01 3000 0 0 0 0   1a04 0 0 0 0  1
00000000 000000 400 801 1202 3 1a05 1003 2c01 3000 0 0 0 0   3000 0 0 0 0  1
# kill_id clears the jump flag
00000000 110000 400 801 1202 3 1a05 1003 2c01 3000 0 0 0 0   3000 0 0 0 0  1
10010000 000000 400 801 1202 3 1a05 1003 2c01 3000 0 0 0 0   3004 0 0 0 0  1
00001010 000000 400 801 1202 3 1a05 1003 2c01 3000 0 0 0 0   400  0 0 0 0  1
00000000 000000 400 801 1202 3 1a05 1003 2c01 3000 0 0 0 0   400  0 0 0 0  1
# address faults from the mask
00000000 110000 400 801 1202 3 1a05 1003 2c01 3000 0 0 0 10  400  0 0 0 0  1
00000000 000000 400 801 1202 3 1a05 1003 2c01 3000 0 0 0 0   414  1 0 0 0  1
00000000 110000 400 801 1202 3 1a05 1003 2c01 3000 1 0 0 0   414  0 1 1 1  1
00000000 110000 400 801 1202 3 1a05 1003 2c01 3000 0 0 0 1   416  0 1 0 1  1
00000000 110000 400 801 1202 3 1a05 1003 2c01 3000 0 0 0 0   41b  1 1 0 1  1
00000000 000000 400 801 1202 3 1a05 1003 2c01 3000 0 0 0 0   41f  0 1 0 2  1
# decision faults, then a long branch fault run to saturate the count
00000010 000000 400 801 1202 3 1a05 1003 2c01 3000 0 0 0 0   41f  1 1 0 2  1
00000000 000000 400 801 1202 3 1a05 1003 2c01 3000 0 0 0 0   41f  0 1 0 3  1
10100000 000000 400 801 1202 3 1a05 1003 2c01 3000 0 0 0 0   41f  0 1 0 3  1
00000000 000000 400 801 1202 3 1a05 1003 2c01 3000 0 0 0 0   800  1 1 0 3  1
00000000 000000 400 801 1202 3 1a05 1003 2c01 3000 0 0 0 0   800  1 1 0 ff 260
00000100 000000 400 801 1202 3 1a05 1003 2c01 3000 0 0 0 0   800  1 1 0 ff 1
00000000 000000 400 801 1202 3 1a05 1003 2c01 3000 0 0 0 0   800  0 1 0 ff 1
00000000 000000 400 801 1202 3 1a05 1003 2c01 3000 0 0 0 0   800  0 1 0 ff 3

//--- pc_guard.f
pc_guard_pkg.sv
pc_fetch.sv
pc_check.sv
pc_alert.sv
pc_guard_top.sv
tb_pc_guard.sv

//--- run_sim.sh
#!/bin/sh
# Builds the pc_guard testbench with Verilator and runs it from the project root
# Exit status is nonzero when the build fails or the simulation ends in $fatal

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir &&
verilator --binary --timing --top-module tb_pc_guard -f pc_guard.f &&
./obj_dir/Vtb_pc_guard ||
{ echo "pc_guard simulation did not complete cleanly"; exit 1; }

//--- tb_pc_guard.sv
// Replays the golden vectors on pc_guard_top one vector per cycle
// Outputs are sampled just before the next rising edge
// A held vector is checked on its last cycle only
`timescale 1ns/1ps

module tb_pc_guard;

  localparam int unsigned HALF_PERIOD = 2;
  localparam int unsigned DRIVE_DLY   = 1;
  localparam int unsigned SAMPLE_DLY  = 3;
  localparam int unsigned RST_CYCLES  = 5;
  localparam int unsigned TIMEOUT_PAD = 50;
  localparam logic [31:0] SEED        = 32'h351c;

  // One golden vector with stimulus first and expected outputs after it
  typedef struct packed {
    pc_guard_pkg::ctrl_fsm_t   ctrl;
    pc_guard_pkg::pipe_flow_t  flow;
    pc_guard_pkg::pc_targets_t tgt;
    logic                      compressed;
    logic                      branch_decision;
    logic                      id_ex_valid;
    pc_guard_pkg::addr_t       fault_mask;
    pc_guard_pkg::addr_t       exp_pc;
    logic                      exp_err;
    logic                      exp_alarm;
    logic                      exp_alert;
    pc_guard_pkg::err_cnt_t    exp_cnt;
    // Number of cycles the vector is held
    logic [15:0]               rep;
  } vec_t;

  logic                      clk;
  logic                      rst_n;
  pc_guard_pkg::ctrl_fsm_t   ctrl;
  pc_guard_pkg::pipe_flow_t  flow;
  pc_guard_pkg::pc_targets_t targets;
  logic                      compressed;
  logic                      id_ex_valid;
  logic                      branch_decision;
  pc_guard_pkg::addr_t       fault_mask;
  pc_guard_pkg::addr_t       pc_if;
  logic                      pc_err;
  logic                      alarm;
  logic                      alert;
  pc_guard_pkg::err_cnt_t    err_cnt;

  vec_t                      vecs[$];
  int unsigned               total_cycles;
  int unsigned               cycle_limit;
  int unsigned               cycle_cnt;

  pc_guard_top pc_guard_top_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .ctrl_i            (ctrl),
    .flow_i            (flow),
    .targets_i         (targets),
    .compressed_i      (compressed),
    .id_ex_valid_i     (id_ex_valid),
    .branch_decision_i (branch_decision),
    .fault_mask_i      (fault_mask),
    .pc_if_o           (pc_if),
    .pc_err_o          (pc_err),
    .alarm_o           (alarm),
    .alert_o           (alert),
    .err_cnt_o         (err_cnt)
  );

  ////////////////////
  // Clock and timeout
  ////////////////////

  always #(HALF_PERIOD) clk = ~clk;

  // Limit is set once the vectors are loaded
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      $display("test failed");
      $fatal(1, "Timeout, the run went past %0d cycles", cycle_limit);
    end
  end

  ////////////////////
  // Helpers
  ////////////////////

  // Idle means no pc_set and no valid in any stage
  function automatic logic is_idle(input vec_t v);
    return !v.ctrl.pc_set && !v.flow.if_valid && !v.flow.id_valid && !v.flow.ex_valid;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
      $display("test failed");
      $fatal(1, "Output mismatch on %s", name);
    end
  endtask

  task automatic load_vectors();
    int          fd;
    int          n_fields;
    int          rep;
    string       line;
    logic [7:0]  ctrl_bits;
    logic [5:0]  flow_bits;
    logic [31:0] jt;
    logic [31:0] bt;
    logic [31:0] mepc;
    logic [31:0] mtvec;
    logic [31:0] dpc;
    logic [31:0] boot;
    logic [31:0] nmi;
    logic [31:0] wbn;
    logic        cmp;
    logic        bd;
    logic        idex;
    logic [31:0] mask;
    logic [31:0] exp_pc;
    logic        exp_err;
    logic        exp_alarm;
    logic        exp_alert;
    logic [31:0] exp_cnt;
    vec_t        v;
    fd = $fopen("pc_guard_golden.txt", "r");
    if (fd == 0) begin
      $display("test failed");
      $fatal(1, "Cannot open pc_guard_golden.txt for reading");
    end
    while ($fgets(line, fd) != 0) begin
      // Skip comment lines and empty lines
      if (line.len() > 1 && line.getc(0) != "#") begin
        n_fields = $sscanf(line, "%b %b %h %h %h %h %h %h %h %h %b %b %b %h %h %b %b %b %h %d",
                           ctrl_bits, flow_bits, jt, bt, mepc, mtvec, dpc, boot, nmi, wbn,
                           cmp, bd, idex, mask, exp_pc, exp_err, exp_alarm, exp_alert,
                           exp_cnt, rep);
        if (n_fields != 20 || rep < 1) begin
          $display("test failed");
          $fatal(1, "Malformed golden vector line: %s", line);
        end
        v.ctrl                  = pc_guard_pkg::ctrl_fsm_t'(ctrl_bits);
        v.flow                  = pc_guard_pkg::pipe_flow_t'(flow_bits);
        v.tgt.jump_target       = jt;
        v.tgt.branch_target     = bt;
        v.tgt.mepc              = mepc;
        v.tgt.mtvec_addr        = mtvec[24:0];
        v.tgt.dpc               = dpc;
        v.tgt.boot_addr         = boot;
        v.tgt.nmi_addr          = nmi;
        v.tgt.wb_next_pc        = wbn;
        v.compressed            = cmp;
        v.branch_decision       = bd;
        v.id_ex_valid           = idex;
        v.fault_mask            = mask;
        v.exp_pc                = exp_pc;
        v.exp_err               = exp_err;
        v.exp_alarm             = exp_alarm;
        v.exp_alert             = exp_alert;
        v.exp_cnt               = exp_cnt[7:0];
        v.rep                   = 16'(rep);
        vecs.push_back(v);
      end
    end
    $fclose(fd);
    if (vecs.size() == 0) begin
      $display("test failed");
      $fatal(1, "The golden file holds no vectors");
    end
  endtask

  // Idle cycles get random ready levels as back-pressure
  task automatic apply_vector(input vec_t v);
    logic [31:0]              rnd;
    pc_guard_pkg::pipe_flow_t fl;
    fl = v.flow;
    if (is_idle(v)) begin
      rnd         = $urandom();
      fl.id_ready = rnd[0];
      fl.ex_ready = rnd[1];
      fl.wb_ready = rnd[2];
    end
    ctrl            = v.ctrl;
    flow            = fl;
    targets         = v.tgt;
    compressed      = v.compressed;
    branch_decision = v.branch_decision;
    id_ex_valid     = v.id_ex_valid;
    fault_mask      = v.fault_mask;
  endtask

  task automatic check_outputs(input vec_t v);
    check_val("pc_if_o", pc_if, v.exp_pc);
    check_val("pc_err_o", 32'(pc_err), 32'(v.exp_err));
    check_val("alarm_o", 32'(alarm), 32'(v.exp_alarm));
    check_val("alert_o", 32'(alert), 32'(v.exp_alert));
    check_val("err_cnt_o", 32'(err_cnt), 32'(v.exp_cnt));
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    int unsigned r;
    clk             = 1'b0;
    rst_n           = 1'b0;
    ctrl            = '0;
    flow            = '0;
    targets         = '0;
    compressed      = 1'b0;
    id_ex_valid     = 1'b0;
    branch_decision = 1'b0;
    fault_mask      = '0;
    cycle_cnt       = 0;
    cycle_limit     = 0;
    void'($urandom(SEED));

    load_vectors();
    total_cycles = 0;
    foreach (vecs[i]) begin
      total_cycles = total_cycles + 32'(vecs[i].rep);
    end
    cycle_limit = RST_CYCLES + total_cycles + TIMEOUT_PAD;

    // PC reset value comes from boot_addr while reset is held
    targets = vecs[0].tgt;
    repeat (RST_CYCLES) @(posedge clk);
    #(DRIVE_DLY);
    rst_n = 1'b1;

    foreach (vecs[i]) begin
      for (r = 0; r < 32'(vecs[i].rep); r++) begin
        apply_vector(vecs[i]);
        #(SAMPLE_DLY - DRIVE_DLY);
        if (r == 32'(vecs[i].rep) - 1) begin
          check_outputs(vecs[i]);
        end
        @(posedge clk);
        #(DRIVE_DLY);
      end
    end

    $display("test passed");
    $finish;
  end

endmodule

//--- pc_guard_top.sv
// Hardened fetch top, pc_err one cycle after a bad event and alert_o two cycles after
// Controller, decoder, ALU and CSRs sit outside
`timescale 1ns/1ps

module pc_guard_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  pc_guard_pkg::ctrl_fsm_t   ctrl_i,
  input  pc_guard_pkg::pipe_flow_t  flow_i,
  input  pc_guard_pkg::pc_targets_t targets_i,
  input  logic                      compressed_i,
  input  logic                      id_ex_valid_i,
  input  logic                      branch_decision_i,
  // Fault campaign hook, XORed into every PC load
  input  pc_guard_pkg::addr_t       fault_mask_i,
  output pc_guard_pkg::addr_t       pc_if_o,
  output logic                      pc_err_o,
  output logic                      alarm_o,
  output logic                      alert_o,
  output pc_guard_pkg::err_cnt_t    err_cnt_o
);

  pc_guard_pkg::addr_t       pc_if;
  pc_guard_pkg::if_id_pipe_t if_id;
  logic                      pc_err;

  // Datapath under check
  pc_fetch pc_fetch_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctrl_i       (ctrl_i),
    .flow_i       (flow_i),
    .targets_i    (targets_i),
    .compressed_i (compressed_i),
    .fault_mask_i (fault_mask_i),
    .pc_if_o      (pc_if),
    .if_id_o      (if_id)
  );

  // Independent recompute of the same command
  pc_check pc_check_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .ctrl_i            (ctrl_i),
    .flow_i            (flow_i),
    .targets_i         (targets_i),
    .pc_if_i           (pc_if),
    .if_id_i           (if_id),
    .id_ex_valid_i     (id_ex_valid_i),
    .branch_decision_i (branch_decision_i),
    .pc_err_o          (pc_err)
  );

  pc_alert pc_alert_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .pc_err_i  (pc_err),
    .alarm_o   (alarm_o),
    .alert_o   (alert_o),
    .err_cnt_o (err_cnt_o)
  );

  assign pc_if_o  = pc_if;
  assign pc_err_o = pc_err;

endmodule

//--- pc_alert.sv
// Turns the checker's level error into a sticky alarm, an alert pulse and a count
// Alarm and count clear only on reset
`timescale 1ns/1ps

module pc_alert (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   pc_err_i,
  output logic                   alarm_o,
  output logic                   alert_o,
  output pc_guard_pkg::err_cnt_t err_cnt_o
);

  logic                   alarm_q;
  logic                   alert_q;
  pc_guard_pkg::err_cnt_t err_cnt_q;
  logic                   cnt_sat;

  ////////////////////
  // Alarm and alert
  ////////////////////

  // Alert fires only on the first error, later ones hit a raised alarm
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      alarm_q <= 1'b0;
      alert_q <= 1'b0;
    end else begin
      alarm_q <= alarm_q || pc_err_i;
      alert_q <= pc_err_i && !alarm_q;
    end
  end

  ////////////////////
  // Error counter
  ////////////////////

  assign cnt_sat = (err_cnt_q == pc_guard_pkg::ERR_CNT_MAX);

  // One count per error cycle, holds at full scale
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      err_cnt_q <= '0;
    end else if (pc_err_i && !cnt_sat) begin
      err_cnt_q <= err_cnt_q + 1'b1;
    end
  end

  assign alarm_o   = alarm_q;
  assign alert_o   = alert_q;
  assign err_cnt_o = err_cnt_q;

endmodule

//--- pc_check.sv
// Recomputes the IF PC and checks jump and branch decisions against ID and EX
// WB_PLUS4 targets are not recomputed, pc_err stays low until the first pc_set
`timescale 1ns/1ps

module pc_check (
  input  logic                      clk,
  input  logic                      rst_n,
  input  pc_guard_pkg::ctrl_fsm_t   ctrl_i,
  input  pc_guard_pkg::pipe_flow_t  flow_i,
  input  pc_guard_pkg::pc_targets_t targets_i,
  input  pc_guard_pkg::addr_t       pc_if_i,
  input  pc_guard_pkg::if_id_pipe_t if_id_i,
  input  logic                      id_ex_valid_i,
  input  logic                      branch_decision_i,
  output logic                      pc_err_o
);

  // Registered view of the last controller command
  logic                  pc_set_q;
  pc_guard_pkg::pc_mux_e pc_mux_q;
  logic                  if_id_q;
  logic                  compare_enable_q;

  // Sticky taken flags, held until the instruction leaves its stage
  logic                  jmp_taken_q;
  logic                  bch_taken_q;

  // Own decode of the current command
  logic                  set_jump;
  logic                  set_branch;
  logic                  set_checked;
  logic                  id_done;
  logic                  ex_done;

  pc_guard_pkg::addr_t   incr_addr;
  pc_guard_pkg::addr_t   ctrl_flow_addr;
  pc_guard_pkg::addr_t   check_addr;

  logic                  addr_err;
  logic                  jump_taken_err;
  logic                  branch_taken_err;
  logic                  jump_untaken_err;
  logic                  branch_untaken_err;
  logic                  ctrl_flow_err;

  ////////////////////
  // Command decode
  ////////////////////

  assign set_jump    = ctrl_i.pc_set &&
                       ((ctrl_i.pc_mux == pc_guard_pkg::PC_JUMP) ||
                        (ctrl_i.pc_mux == pc_guard_pkg::PC_MRET));
  assign set_branch  = ctrl_i.pc_set && (ctrl_i.pc_mux == pc_guard_pkg::PC_BRANCH);
  // No recompute for a restart from WB
  assign set_checked = ctrl_i.pc_set && (ctrl_i.pc_mux != pc_guard_pkg::PC_WB_PLUS4);

  assign id_done = flow_i.id_valid && flow_i.ex_ready;
  assign ex_done = flow_i.ex_valid && flow_i.wb_ready;

  ////////////////////
  // Address check
  ////////////////////

  // Expected PC after a sequential step, from the entry now in ID
  assign incr_addr = if_id_i.pc + (if_id_i.compressed ? pc_guard_pkg::PC_INCR_C
                                                      : pc_guard_pkg::PC_INCR_U);

  // Target from the registered mux code
  // Written as a priority chain so it does not share structure with the fetch mux
  // A glitched pc_mux picks a wrong target here and shows as an address mismatch
  assign ctrl_flow_addr =
    (pc_mux_q == pc_guard_pkg::PC_JUMP)     ? targets_i.jump_target      :
    (pc_mux_q == pc_guard_pkg::PC_BRANCH)   ? targets_i.branch_target    :
    (pc_mux_q == pc_guard_pkg::PC_MRET)     ? targets_i.mepc             :
    (pc_mux_q == pc_guard_pkg::PC_TRAP_EXC) ? {targets_i.mtvec_addr, 7'h00} :
    (pc_mux_q == pc_guard_pkg::PC_TRAP_NMI) ? targets_i.nmi_addr         :
    (pc_mux_q == pc_guard_pkg::PC_DRET)     ? targets_i.dpc              :
                                              {targets_i.boot_addr[31:2], 2'b00};

  // Halfword aligned target, bit 0 tied low as in fetch
  assign check_addr = pc_set_q ? {ctrl_flow_addr[31:1], 1'b0} : incr_addr;

  // Only meaningful the cycle after a checked pc_set or an IF to ID transfer
  assign addr_err = (pc_set_q || if_id_q) && (check_addr != pc_if_i);

  ////////////////////
  // Decision check
  ////////////////////

  // Taken flag set but the instruction that caused it is gone
  // Raw flags are used so a halt or kill of instr_valid does not matter here
  assign jump_taken_err   = jmp_taken_q && !ctrl_i.jump_in_id_raw;
  assign branch_taken_err = bch_taken_q && !(ctrl_i.branch_in_ex_raw && branch_decision_i);

  // Valid jump or taken branch present but nothing was taken
  assign jump_untaken_err   = !jmp_taken_q && ctrl_i.jump_in_id_raw && if_id_i.instr_valid;
  assign branch_untaken_err = !bch_taken_q && ctrl_i.branch_in_ex_raw &&
                              id_ex_valid_i && branch_decision_i;

  assign ctrl_flow_err = jump_taken_err || branch_taken_err ||
                         jump_untaken_err || branch_untaken_err;

  ////////////////////
  // Flags
  ////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      pc_set_q         <= 1'b0;
      pc_mux_q         <= pc_guard_pkg::PC_BOOT;
      if_id_q          <= 1'b0;
      compare_enable_q <= 1'b0;
      jmp_taken_q      <= 1'b0;
      bch_taken_q      <= 1'b0;
    end else begin
      pc_set_q <= set_checked;
      // A pc_set overrides the step, so no sequential compare follows it
      if_id_q  <= flow_i.if_valid && flow_i.id_ready && !ctrl_i.pc_set;

      if (ctrl_i.pc_set) begin
        pc_mux_q         <= ctrl_i.pc_mux;
        compare_enable_q <= 1'b1;
      end

      // Jump and mret are taken in ID
      if (id_done || ctrl_i.kill_id) begin
        jmp_taken_q <= 1'b0;
      end else if (set_jump) begin
        jmp_taken_q <= 1'b1;
      end

      // Branches are taken in EX
      if (ex_done || ctrl_i.kill_ex) begin
        bch_taken_q <= 1'b0;
      end else if (set_branch) begin
        bch_taken_q <= 1'b1;
      end
    end
  end

  // Level error, quiet until the first pc_set
  assign pc_err_o = (addr_err || ctrl_flow_err) && compare_enable_q;

endmodule

//--- pc_fetch.sv
// IF stage PC generator and IF/ID register
// boot_addr is the PC reset value and must be stable while rst_n is low
`timescale 1ns/1ps

module pc_fetch (
  input  logic                      clk,
  input  logic                      rst_n,
  input  pc_guard_pkg::ctrl_fsm_t   ctrl_i,
  input  pc_guard_pkg::pipe_flow_t  flow_i,
  input  pc_guard_pkg::pc_targets_t targets_i,
  input  logic                      compressed_i,
  input  pc_guard_pkg::addr_t       fault_mask_i,
  output pc_guard_pkg::addr_t       pc_if_o,
  output pc_guard_pkg::if_id_pipe_t if_id_o
);

  pc_guard_pkg::addr_t       pc_q;
  pc_guard_pkg::addr_t       pc_d;
  pc_guard_pkg::addr_t       target;
  pc_guard_pkg::addr_t       pc_incr;
  pc_guard_pkg::if_id_pipe_t if_id_q;
  logic                      if_id_xfer;
  logic                      id_done;
  logic                      pc_load;

  ////////////////////
  // Target mux
  ////////////////////

  always_comb begin
    target = {targets_i.boot_addr[31:2], 2'b00};
    case (ctrl_i.pc_mux)
      pc_guard_pkg::PC_BOOT:     target = {targets_i.boot_addr[31:2], 2'b00};
      pc_guard_pkg::PC_JUMP:     target = targets_i.jump_target;
      pc_guard_pkg::PC_BRANCH:   target = targets_i.branch_target;
      pc_guard_pkg::PC_MRET:     target = targets_i.mepc;
      // Trap vector base is 128 byte aligned
      pc_guard_pkg::PC_TRAP_EXC: target = {targets_i.mtvec_addr, 7'h00};
      pc_guard_pkg::PC_TRAP_NMI: target = targets_i.nmi_addr;
      pc_guard_pkg::PC_DRET:     target = targets_i.dpc;
      // Restart after WB that the checker does not recompute
      pc_guard_pkg::PC_WB_PLUS4: target = targets_i.wb_next_pc;
    endcase
  end

  ////////////////////
  // Next PC
  ////////////////////

  assign if_id_xfer = flow_i.if_valid && flow_i.id_ready;
  assign id_done    = flow_i.id_valid && flow_i.ex_ready;

  // Step over the instruction now leaving IF
  assign pc_incr = pc_q + (compressed_i ? pc_guard_pkg::PC_INCR_C : pc_guard_pkg::PC_INCR_U);

  // pc_set wins over a sequential step
  // Instructions are halfword aligned so bit 0 is always cleared on a jump
  assign pc_d    = ctrl_i.pc_set ? {target[31:1], 1'b0} : pc_incr;
  assign pc_load = ctrl_i.pc_set || if_id_xfer;

  // Fault mask only corrupts a load and a held PC stays clean
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= {targets_i.boot_addr[31:2], 2'b00};
    end else if (pc_load) begin
      pc_q <= pc_d ^ fault_mask_i;
    end
  end

  ////////////////////
  // IF/ID register
  ////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      if_id_q <= '0;
    end else begin
      // Kill has priority over a new entry
      if (ctrl_i.kill_id) begin
        if_id_q.instr_valid <= 1'b0;
      end else if (if_id_xfer) begin
        if_id_q.instr_valid <= 1'b1;
      end else if (id_done) begin
        // ID moved on with nothing new behind it
        if_id_q.instr_valid <= 1'b0;
      end

      // Payload follows the transfer
      if (if_id_xfer) begin
        if_id_q.pc         <= pc_q;
        if_id_q.compressed <= compressed_i;
      end
    end
  end

  assign pc_if_o = pc_q;
  assign if_id_o = if_id_q;

endmodule

//--- pc_guard_pkg.sv
// Shared types for the pc_guard subsystem. Interrupt and debug halt targets are not modelled
// Every instruction retires in a single operation

package pc_guard_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Byte address for the PC and all jump targets
  typedef logic [31:0] addr_t;

  // Upper trap vector base, padded with 7 zero bits to make an address
  typedef logic [24:0] mtvec_addr_t;

  // Sequential increments, compressed and uncompressed
  localparam addr_t PC_INCR_C = 32'd2;
  localparam addr_t PC_INCR_U = 32'd4;

  // Saturating error counter
  localparam int unsigned ERR_CNT_W = 8;
  typedef logic [ERR_CNT_W-1:0] err_cnt_t;
  localparam err_cnt_t ERR_CNT_MAX = '1;

  ////////////////////
  // Controller
  ////////////////////

  // PC source select, all eight codes in use
  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_MRET     = 3'd3,
    PC_TRAP_EXC = 3'd4,
    PC_TRAP_NMI = 3'd5,
    PC_DRET     = 3'd6,
    PC_WB_PLUS4 = 3'd7
  } pc_mux_e;

  // Controller command, decoded separately by fetch and checker
  typedef struct packed {
    logic    pc_set;
    pc_mux_e pc_mux;
    logic    kill_id;
    logic    kill_ex;
    // Raw flags ignore halt and kill, they only say what sits in the stage
    logic    jump_in_id_raw;
    logic    branch_in_ex_raw;
  } ctrl_fsm_t;

  // Stage valid and ready levels, a transfer is valid and ready high together
  typedef struct packed {
    logic if_valid;
    logic id_ready;
    logic id_valid;
    logic ex_ready;
    logic ex_valid;
    logic wb_ready;
  } pipe_flow_t;

  // All PC targets the controller can select
  typedef struct packed {
    addr_t       jump_target;
    addr_t       branch_target;
    addr_t       mepc;
    mtvec_addr_t mtvec_addr;
    addr_t       dpc;
    addr_t       boot_addr;
    addr_t       nmi_addr;
    addr_t       wb_next_pc;
  } pc_targets_t;

  ////////////////////
  // Pipeline
  ////////////////////

  // IF/ID register contents
  typedef struct packed {
    logic  instr_valid;
    logic  compressed;
    addr_t pc;
  } if_id_pipe_t;

endpackage
